// ==== sim.f ====
+incdir+hw
hw/issue_pkg.sv
hw/issue_cfg.sv
hw/issue_queue.sv
hw/issue_select.sv
hw/issue_stage.sv
tests/tb_issue_stage.sv

// ==== Bender.yml ====
package:
  name: issue_stage

sources:
  - include_dirs:
      - hw
    files:
      - hw/issue_pkg.sv
      - hw/issue_cfg.sv
      - hw/issue_queue.sv
      - hw/issue_select.sv
      - hw/issue_stage.sv

  - target: test
    include_dirs:
      - hw
    files:
      - tests/tb_issue_stage.sv

// ==== tests/tb_issue_stage.sv ====
/* issue stage testbench */

`default_nettype none

`include "issue_macros.svh"

module tb_issue_stage;

   timeunit 1ns;
   timeprecision 1ps;

   import issue_pkg::*;

   localparam int          N_CYC = 4000;
   localparam logic [31:0] SEED  = 32'ha06c_0e20;

   logic                     clk;
   logic                     arst_n;
   logic                     disp_vld;
   dispatch_t                disp;
   logic                     wb_vld;
   logic [`PREG_W-1:0]       wb_tag;
   logic                     rel_vld;
   logic [`ISQ_IDX_W-1:0]    rel_idx;
   logic                     cfg_we;
   cfg_t                     cfg_data;
   logic [`FU_NUM-1:0]       fu_rdy;
   issue_pkt_t [`FU_NUM-1:0] iss;

   // reference queue, predicted packets, rng state
   logic               m_vld [`ISQ_DEPTH];
   logic               m_wat [`ISQ_DEPTH];
   dispatch_t          m_ent [`ISQ_DEPTH];
   logic [`FU_NUM-1:0] m_mask;
   issue_pkt_t         exp_pkt [`FU_NUM];
   int                 iss_cnt [`FU_NUM];
   logic [31:0]        seed;

   issue_stage i_dut (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .disp_vld_i (disp_vld),
      .disp_i     (disp),
      .wb_vld_i   (wb_vld),
      .wb_tag_i   (wb_tag),
      .rel_vld_i  (rel_vld),
      .rel_idx_i  (rel_idx),
      .cfg_we_i   (cfg_we),
      .cfg_data_i (cfg_data),
      .fu_rdy_i   (fu_rdy),
      .iss_o      (iss)
   );

   // 20 ns period
   always #10 clk = ~clk;

   //////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      seed = seed ^ (seed << 13);
      seed = seed ^ (seed >> 17);
      seed = seed ^ (seed << 5);
      return seed;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("Fail at %0d ns: %s got %h expected %h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   // port routing by op kind, adds split on slot index mod 3
   function automatic bit routes(input op_class_t op, input int p, input int i);
      case (p)
         0: return op.mul;
         1: return op.br || op.jmp || (op.add && (i % 3 == 0));
         2: return op.add && (i % 3 != 0);
         default: return op.addr;
      endcase
   endfunction

   function automatic bit eligible(input int i, input int p);
      return m_vld[i] && m_wat[i] && m_ent[i].psrc1_rdy && m_ent[i].psrc2_rdy
         && fu_rdy[p] && m_mask[p] && routes(m_ent[i].op, p, i);
   endfunction

   //////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////

   task automatic drive_random();
      int                 free_q[$];
      int                 done_q[$];
      logic [`PREG_W-1:0] tags[$];
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (!m_vld[i])
            free_q.push_back(i);
         else if (!m_wat[i])
            done_q.push_back(i);
         // sources still waiting for a writeback
         if (m_vld[i] && !m_ent[i].psrc1_rdy)
            tags.push_back(m_ent[i].psrc1);
         if (m_vld[i] && !m_ent[i].psrc2_rdy)
            tags.push_back(m_ent[i].psrc2);
      end
      // payload is random even without the strobe
      disp           = dispatch_t'({next_rand(), next_rand()});
      disp.op        = op_class_t'(5'b00001 << (next_rand() % 5));
      disp_vld       = (free_q.size() > 0) && (next_rand() % 2 == 1);
      if (disp_vld)
         disp.idx = `ISQ_IDX_W'(free_q[next_rand() % free_q.size()]);
      // mostly useful wakeup tags
      wb_vld = (next_rand() % 4) != 0;
      wb_tag = `PREG_W'(next_rand());
      if (tags.size() > 0 && (next_rand() % 4) != 0)
         wb_tag = tags[next_rand() % tags.size()];
      // free an entry that already left
      rel_vld = (done_q.size() > 0) && (next_rand() % 3 == 0);
      rel_idx = `ISQ_IDX_W'(next_rand());
      if (rel_vld)
         rel_idx = `ISQ_IDX_W'(done_q[next_rand() % done_q.size()]);
      // rare mask writes, bits biased toward enabled
      cfg_we         = (next_rand() % 32) == 0;
      cfg_data.fu_en = `FU_NUM'(next_rand() | next_rand());
      for (int p = 0; p < `FU_NUM; p++)
         fu_rdy[p] = (next_rand() % 8) != 0;
   endtask

   //////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////

   // predicts the packets of the coming edge, then advances the queue
   task automatic model_step();
      logic [`ISQ_DEPTH-1:0] taken;
      taken = '0;
      for (int p = 0; p < `FU_NUM; p++)
      begin
         exp_pkt[p] = '0;
         for (int i = 0; i < `ISQ_DEPTH; i++)
         begin
            if (!exp_pkt[p].vld && eligible(i, p))
            begin
               exp_pkt[p] = '{vld: 1'b1, idx: m_ent[i].idx, psrc1: m_ent[i].psrc1,
                              psrc2: m_ent[i].psrc2, pdest: m_ent[i].pdest,
                              op: m_ent[i].op, opcode: m_ent[i].opcode};
               taken[i] = 1'b1;
            end
         end
      end
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         if (taken[i])
            m_wat[i] = 1'b0;
         if (wb_vld && m_vld[i] && m_ent[i].psrc1 == wb_tag)
            m_ent[i].psrc1_rdy = 1'b1;
         if (wb_vld && m_vld[i] && m_ent[i].psrc2 == wb_tag)
            m_ent[i].psrc2_rdy = 1'b1;
      end
      if (rel_vld)
         m_vld[rel_idx] = 1'b0;
      if (disp_vld)
      begin
         m_ent[disp.idx]           = disp;
         // writeback in the dispatch cycle also counts
         m_ent[disp.idx].psrc1_rdy = disp.psrc1_rdy || (wb_vld && disp.psrc1 == wb_tag);
         m_ent[disp.idx].psrc2_rdy = disp.psrc2_rdy || (wb_vld && disp.psrc2 == wb_tag);
         m_vld[disp.idx]           = 1'b1;
         m_wat[disp.idx]           = 1'b1;
      end
      if (cfg_we)
         m_mask = cfg_data.fu_en;
   endtask

   task automatic compare_ports();
      for (int p = 0; p < `FU_NUM; p++)
      begin
         check_value($sformatf("iss_o[%0d].vld", p), iss[p].vld, exp_pkt[p].vld);
         if (exp_pkt[p].vld)
         begin
            iss_cnt[p]++;
            check_value($sformatf("iss_o[%0d]", p), iss[p], exp_pkt[p]);
         end
      end
   endtask

   //////////////////////////////////////////////////
   // main sequence and watchdog
   //////////////////////////////////////////////////

   initial
   begin
      seed     = SEED;
      clk      = 1'b0;
      arst_n   = 1'b0;
      disp_vld = 1'b0;
      disp     = '0;
      wb_vld   = 1'b0;
      wb_tag   = '0;
      rel_vld  = 1'b0;
      rel_idx  = '0;
      cfg_we   = 1'b0;
      cfg_data = '0;
      fu_rdy   = '1;
      m_mask   = '1;
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         m_vld[i] = 1'b0;
         m_wat[i] = 1'b0;
         m_ent[i] = '0;
      end
      for (int p = 0; p < `FU_NUM; p++)
      begin
         exp_pkt[p] = '0;
         iss_cnt[p] = 0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      // all ports idle in reset
      compare_ports();
      arst_n = 1'b1;
      for (int c = 0; c < N_CYC; c++)
      begin
         drive_random();
         model_step();
         @(posedge clk);
         #1;
         compare_ports();
         @(negedge clk);
      end
      // every port must have seen traffic
      for (int p = 0; p < `FU_NUM; p++)
         check_value($sformatf("port %0d used", p), iss_cnt[p] > 0, 1);
      $display("No errors");
      $finish;
   end

   // stimulus length plus reset and some slack
   initial
   begin
      #((N_CYC + 20) * 20);
      $display("watchdog expired before the stimulus loop finished");
      $display("Errors found");
      $fatal(1, "timeout");
   end

endmodule

`default_nettype wire

// ==== hw/issue_stage.sv ====
/* issue stage top */

`default_nettype none

`include "issue_macros.svh"

module issue_stage (
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic                                disp_vld_i,
   input  issue_pkg::dispatch_t                disp_i,
   input  logic                                wb_vld_i,
   input  logic [`PREG_W-1:0]                  wb_tag_i,
   input  logic                                rel_vld_i,
   input  logic [`ISQ_IDX_W-1:0]               rel_idx_i,
   input  logic                                cfg_we_i,
   input  issue_pkg::cfg_t                     cfg_data_i,
   input  logic [`FU_NUM-1:0]                  fu_rdy_i,
   output issue_pkg::issue_pkt_t [`FU_NUM-1:0] iss_o
);

   import issue_pkg::*;

   // queue lines toward select, wait clears back
   entry_t [`ISQ_DEPTH-1:0] entries;
   logic [`ISQ_DEPTH-1:0]   clr_wat;
   cfg_t                    cfg;

   issue_cfg i_cfg (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_data_i (cfg_data_i),
      .cfg_o      (cfg)
   );

   issue_queue i_queue (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .disp_vld_i (disp_vld_i),
      .disp_i     (disp_i),
      .wb_vld_i   (wb_vld_i),
      .wb_tag_i   (wb_tag_i),
      .rel_vld_i  (rel_vld_i),
      .rel_idx_i  (rel_idx_i),
      .clr_wat_i  (clr_wat),
      .entries_o  (entries)
   );

   issue_select i_select (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .entries_i  (entries),
      .fu_rdy_i   (fu_rdy_i),
      .cfg_i      (cfg),
      .clr_wat_o  (clr_wat),
      .iss_o      (iss_o)
   );

endmodule

`default_nettype wire

// ==== hw/issue_select.sv ====
/* per port priority select */

`default_nettype none

`include "issue_macros.svh"

module issue_select (
   input  logic                                   clk_i,
   input  logic                                   arst_n_i,
   input  issue_pkg::entry_t [`ISQ_DEPTH-1:0]     entries_i,
   input  logic [`FU_NUM-1:0]                     fu_rdy_i,
   input  issue_pkg::cfg_t                        cfg_i,
   output logic [`ISQ_DEPTH-1:0]                  clr_wat_o,
   output issue_pkg::issue_pkt_t [`FU_NUM-1:0]    iss_o
);

   import issue_pkg::*;

   logic [`FU_NUM-1:0][`ISQ_DEPTH-1:0] elig;
   logic [`FU_NUM-1:0][`ISQ_DEPTH-1:0] pick;
   issue_pkt_t [`FU_NUM-1:0]           pkt_d;
   issue_pkt_t [`FU_NUM-1:0]           pkt_q;
   logic [`FU_NUM-1:0]                 vld_q;

   // op class to port routing
   // adds split on slot index, branch and jump stay on adder 1
   function automatic logic class_ok(input op_class_t op, input fu_e fu,
                                     input logic slot_m3);
      logic ok;
      case (fu)
         FU_MUL:  ok = op.mul;
         FU_ALU1: ok = op.br | op.jmp | (op.add & slot_m3);
         FU_ALU2: ok = op.add & ~slot_m3;
         FU_ADR:  ok = op.addr;
         default: ok = 1'b0;
      endcase
      return ok;
   endfunction

   // queue line to register read format
   function automatic issue_pkt_t reorder(input entry_t e);
      issue_pkt_t p;
      p.vld    = 1'b1;
      p.idx    = e.d.idx;
      p.psrc1  = e.d.psrc1;
      p.psrc2  = e.d.psrc2;
      p.pdest  = e.d.pdest;
      p.op     = e.d.op;
      p.opcode = e.d.opcode;
      return p;
   endfunction

   //////////////////////////////////////////////////
   // eligibility and pick
   //////////////////////////////////////////////////

   always_comb
   begin
      elig      = '0;
      pick      = '0;
      pkt_d     = '0;
      clr_wat_o = '0;
      for (int p = 0; p < `FU_NUM; p++)
      begin
         // waiting, both sources ready, unit free and enabled
         for (int i = 0; i < `ISQ_DEPTH; i++)
         begin
            elig[p][i] = entries_i[i].vld & entries_i[i].wat
                       & entries_i[i].d.psrc1_rdy & entries_i[i].d.psrc2_rdy
                       & fu_rdy_i[p] & cfg_i.fu_en[p]
                       & class_ok(entries_i[i].d.op, fu_e'(p), (i % 3) == 0);
         end
         // isolate lowest set bit, one-hot or zero
         pick[p] = elig[p] & (~elig[p] + `ISQ_DEPTH'd1);
         // one-hot mux of the chosen line
         for (int i = 0; i < `ISQ_DEPTH; i++)
         begin
            if (pick[p][i])
               pkt_d[p] = reorder(entries_i[i]);
         end
         // ports never share a line, so OR is enough
         clr_wat_o = clr_wat_o | pick[p];
      end
   end

   //////////////////////////////////////////////////
   // issue registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         vld_q <= '0;
      end
      else
      begin
         for (int p = 0; p < `FU_NUM; p++)
            vld_q[p] <= |pick[p];
      end
   end

   // payload only means something under vld_q
   always_ff @(posedge clk_i)
   begin
      pkt_q <= pkt_d;
   end

   always_comb
   begin
      for (int p = 0; p < `FU_NUM; p++)
      begin
         iss_o[p]     = pkt_q[p];
         iss_o[p].vld = vld_q[p];
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // a line must never leave on two ports in the same cycle
   for (genvar a = 0; a < `FU_NUM; a++)
   begin : g_uniq_a
      for (genvar b = a + 1; b < `FU_NUM; b++)
      begin : g_uniq_b
         a_no_dup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
            (vld_q[a] && vld_q[b]) |-> (pkt_q[a].idx != pkt_q[b].idx));
      end
   end

endmodule

`default_nettype wire

// ==== hw/issue_queue.sv ====
/* issue queue entry storage */

`default_nettype none

`include "issue_macros.svh"

module issue_queue (
   input  logic                               clk_i,
   input  logic                               arst_n_i,
   input  logic                               disp_vld_i,
   input  issue_pkg::dispatch_t               disp_i,
   input  logic                               wb_vld_i,
   input  logic [`PREG_W-1:0]                 wb_tag_i,
   input  logic                               rel_vld_i,
   input  logic [`ISQ_IDX_W-1:0]              rel_idx_i,
   input  logic [`ISQ_DEPTH-1:0]              clr_wat_i,
   output issue_pkg::entry_t [`ISQ_DEPTH-1:0] entries_o
);

   import issue_pkg::*;

   // wakeup of the incoming instruction itself
   logic disp_wk1;
   logic disp_wk2;

   assign disp_wk1 = wb_vld_i && (disp_i.psrc1 == wb_tag_i);
   assign disp_wk2 = wb_vld_i && (disp_i.psrc2 == wb_tag_i);

   //////////////////////////////////////////////////
   // per entry state
   //////////////////////////////////////////////////

   for (genvar g = 0; g < `ISQ_DEPTH; g++)
   begin : g_ent
      logic      vld_q;
      logic      wat_q;
      dispatch_t pld_q;
      logic      disp_hit;
      logic      rel_hit;
      logic      wk1;
      logic      wk2;

      // strobes aimed at this slot
      assign disp_hit = disp_vld_i && (disp_i.idx == `ISQ_IDX_W'(g));
      assign rel_hit  = rel_vld_i && (rel_idx_i == `ISQ_IDX_W'(g));

      // tag compare against both stored sources
      assign wk1 = wb_vld_i && (pld_q.psrc1 == wb_tag_i);
      assign wk2 = wb_vld_i && (pld_q.psrc2 == wb_tag_i);

      // valid and wait bits
      // dispatch only lands in a free slot, so it cannot meet a release here
      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            vld_q <= 1'b0;
            wat_q <= 1'b0;
         end
         else if (disp_hit)
         begin
            vld_q <= 1'b1;
            wat_q <= 1'b1;
         end
         else
         begin
            // commit side frees the line
            if (rel_hit)
               vld_q <= 1'b0;
            // picked by a port this cycle, never picked again
            if (clr_wat_i[g])
               wat_q <= 1'b0;
         end
      end

      // payload and source ready bits
      always_ff @(posedge clk_i)
      begin
         if (disp_hit)
         begin
            pld_q           <= disp_i;
            // same-cycle writeback counts as ready at dispatch
            pld_q.psrc1_rdy <= disp_i.psrc1_rdy | disp_wk1;
            pld_q.psrc2_rdy <= disp_i.psrc2_rdy | disp_wk2;
         end
         else if (vld_q)
         begin
            if (wk1)
               pld_q.psrc1_rdy <= 1'b1;
            if (wk2)
               pld_q.psrc2_rdy <= 1'b1;
         end
      end

      assign entries_o[g] = '{vld: vld_q, wat: wat_q, d: pld_q};
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // dispatch must target a slot the commit side already freed
   a_disp_free: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      disp_vld_i |-> !entries_o[disp_i.idx].vld);

   // release only of a line that is still held
   a_rel_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rel_vld_i |-> entries_o[rel_idx_i].vld);

endmodule

`default_nettype wire

// ==== hw/issue_cfg.sv ====
/* unit enable register */

`default_nettype none

module issue_cfg (
   input  logic             clk_i,
   input  logic             arst_n_i,
   input  logic             cfg_we_i,
   input  issue_pkg::cfg_t  cfg_data_i,
   output issue_pkg::cfg_t  cfg_o
);

   import issue_pkg::*;

   // current enable mask
   cfg_t cfg_q;

   //////////////////////////////////////////////////
   // register
   //////////////////////////////////////////////////

   // every unit enabled out of reset
   // a write replaces the whole mask
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cfg_q.fu_en <= '1;
      end
      else if (cfg_we_i)
      begin
         cfg_q <= cfg_data_i;
      end
   end

   // select sees the mask straight from the flop
   assign cfg_o = cfg_q;

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   // an unknown strobe would leave the mask undefined for all later cycles
   a_we_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !$isunknown(cfg_we_i));

endmodule

`default_nettype wire

// ==== hw/issue_pkg.sv ====
/* issue stage types */

`default_nettype none

package issue_pkg;

   `include "issue_macros.svh"

   // issue port numbering, also the bit order of fu_rdy and the enable mask
   typedef enum logic [1:0] {
      FU_MUL  = 2'd0,
      FU_ALU1 = 2'd1,
      FU_ALU2 = 2'd2,
      FU_ADR  = 2'd3
   } fu_e;

   // one bit per operation kind, expected one-hot
   typedef struct packed {
      logic mul;
      logic add;
      logic br;
      logic jmp;
      logic addr;
   } op_class_t;

   // renamed instruction as it arrives from dispatch
   typedef struct packed {
      logic [`ISQ_IDX_W-1:0] idx;
      logic [`PREG_W-1:0]    psrc1;
      logic                  psrc1_rdy;
      logic [`PREG_W-1:0]    psrc2;
      logic                  psrc2_rdy;
      logic [`PREG_W-1:0]    pdest;
      op_class_t             op;
      logic [7:0]            opcode;
   } dispatch_t;

   // stored queue line
   typedef struct packed {
      logic      vld;
      logic      wat;
      dispatch_t d;
   } entry_t;

   // packet toward register read
   typedef struct packed {
      logic                  vld;
      logic [`ISQ_IDX_W-1:0] idx;
      logic [`PREG_W-1:0]    psrc1;
      logic [`PREG_W-1:0]    psrc2;
      logic [`PREG_W-1:0]    pdest;
      op_class_t             op;
      logic [7:0]            opcode;
   } issue_pkt_t;

   // configuration state
   typedef struct packed {
      logic [`FU_NUM-1:0] fu_en;
   } cfg_t;

endpackage

`default_nettype wire

// ==== hw/issue_macros.svh ====
/* issue stage sizing */

`ifndef ISSUE_MACROS_SVH
`define ISSUE_MACROS_SVH

//////////////////////////////////////////////////
// queue geometry
//////////////////////////////////////////////////

// number of issue queue entries
`define ISQ_DEPTH 16
// bits needed to address one entry
`define ISQ_IDX_W 4

//////////////////////////////////////////////////
// rename and execute side
//////////////////////////////////////////////////

// physical register tag width
`define PREG_W 6
// mul, alu1, alu2, address adder
`define FU_NUM 4

`endif
